/* Bender.yml */
package:
  name: cputop

sources:
  - design/cpuPkg.sv
  - design/controlUnit.sv
  - design/alu.sv
  - design/registerFile.sv
  - design/memBusMaster.sv
  - design/instrSequencer.sv
  - design/cpuTop.sv
  - target: simulation
    files:
      - sim/cpuTop_chk.sv
      - sim/cpuTb.sv

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpuPkg::opcodeT                   op,
    input  logic [cpuPkg::DataWidth-1:0] a,
    input  logic [cpuPkg::DataWidth-1:0] b,
    input  logic [cpuPkg::DataWidth-1:0] imm,
    output logic [cpuPkg::DataWidth-1:0] result,
    output logic                         zero,
    output logic                         negative,
    output logic                         overflow
);

    // Signed 4-bit add clamped to 7 and -8
    function automatic logic [3:0] satNibble(input logic [3:0] x, input logic [3:0] y);
        logic [3:0] s;
        s = x + y;
        if (!x[3] && !y[3] && s[3]) begin
            satNibble = 4'h7;
        end else if (x[3] && y[3] && !s[3]) begin
            satNibble = 4'h8;
        end else begin
            satNibble = s;
        end
    endfunction

    logic [15:0] sum;
    logic [15:0] diff;
    logic        addOvf;
    logic        subOvf;
    logic [9:0]  redSum;   // Four signed bytes need 10 bits
    logic [31:0] rotPair;  // Doubled word for rotate
    logic [15:0] addrCalc; // LW and SW effective address
    logic [3:0]  shamt;

    assign shamt  = imm[3:0];
    assign sum    = a + b;
    assign addOvf = (a[15] == b[15]) && (sum[15] != a[15]);
    assign diff   = a - b;
    assign subOvf = (a[15] != b[15]) && (diff[15] != a[15]);

    //////////////////////////////
    // Byte reduction and address
    //////////////////////////////
    assign redSum = {{2{a[15]}}, a[15:8]} + {{2{a[7]}}, a[7:0]}
                  + {{2{b[15]}}, b[15:8]} + {{2{b[7]}}, b[7:0]};
    assign rotPair  = {a, a} >> shamt;
    assign addrCalc = {a[15:1], 1'b0} + {{11{imm[3]}}, imm[3:0], 1'b0}; // Word offset

    always_comb begin
        overflow = 1'b0;
        case (op)
            cpuPkg::opAdd: begin
                result   = addOvf ? (a[15] ? 16'h8000 : 16'h7FFF) : sum;
                overflow = addOvf;
            end
            cpuPkg::opSub: begin
                result   = subOvf ? (a[15] ? 16'h8000 : 16'h7FFF) : diff; // Sign of a wins
                overflow = subOvf;
            end
            cpuPkg::opXor:    result = a ^ b;
            cpuPkg::opRed:    result = {{6{redSum[9]}}, redSum};
            cpuPkg::opSll:    result = a << shamt;
            cpuPkg::opSra:    result = $signed(a) >>> shamt;
            cpuPkg::opRor:    result = rotPair[15:0];
            cpuPkg::opPaddsb: begin
                result = {satNibble(a[15:12], b[15:12]), satNibble(a[11:8], b[11:8]),
                          satNibble(a[7:4], b[7:4]), satNibble(a[3:0], b[3:0])};
            end
            cpuPkg::opLw, cpuPkg::opSw: result = addrCalc;
            cpuPkg::opLlb:    result = {a[15:8], imm[7:0]};
            cpuPkg::opLhb:    result = {imm[7:0], a[7:0]};
            default:          result = a; // Branches, PCS and HLT ignore the ALU
        endcase
    end

    assign zero     = (result == '0);
    assign negative = result[15];

endmodule

/* design/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  cpuPkg::opcodeT opcode, // Opcode from the instruction register
    output logic aluSrc,           // Immediate instead of rt on ALU input b
    output logic memToReg,         // Write back memory data instead of ALU result
    output logic regWrite,         // Register file write
    output logic regSrc,           // rd on read port 1, for LLB and LHB
    output logic memEnable,        // Data access, LW and SW
    output logic memWrite,         // Data write, SW only
    output logic branch,           // PC may take the branch target
    output logic branchReg,        // Target comes from a register, BR
    output logic halt,             // HLT
    output logic pcSave,           // PCS writes PC+2
    output logic zEn,              // Z flag update
    output logic nvEn              // N and V flag update
);

    always_comb begin
        aluSrc    = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        regSrc    = 1'b0;
        memEnable = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        branchReg = 1'b0;
        halt      = 1'b0;
        pcSave    = 1'b0;
        zEn       = 1'b0;
        nvEn      = 1'b0;
        case (opcode)
            cpuPkg::opAdd, cpuPkg::opSub: begin
                regWrite = 1'b1;
                zEn      = 1'b1;
                nvEn     = 1'b1; // Only the saturating adds touch N and V
            end
            cpuPkg::opXor, cpuPkg::opRed: begin
                regWrite = 1'b1;
                zEn      = 1'b1;
            end
            cpuPkg::opSll, cpuPkg::opSra, cpuPkg::opRor: begin
                aluSrc   = 1'b1; // Shift amount from imm
                regWrite = 1'b1;
                zEn      = 1'b1;
            end
            cpuPkg::opPaddsb: regWrite = 1'b1; // No flags at all
            cpuPkg::opLw: begin
                aluSrc    = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
                memEnable = 1'b1;
            end
            cpuPkg::opSw: begin
                aluSrc    = 1'b1;
                memEnable = 1'b1;
                memWrite  = 1'b1;
            end
            cpuPkg::opLlb, cpuPkg::opLhb: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                regSrc   = 1'b1; // Old rd value keeps the other byte
            end
            cpuPkg::opB:  branch = 1'b1;
            cpuPkg::opBr: begin
                branch    = 1'b1;
                branchReg = 1'b1;
            end
            cpuPkg::opPcs: begin
                regWrite = 1'b1;
                pcSave   = 1'b1;
            end
            cpuPkg::opHlt: halt = 1'b1;
            default: ;
        endcase
    end

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int DataWidth    = 16; // Word, address and register width
    localparam int RegAddrWidth = 4;  // Register index width

    // Opcodes in instruction bits 15 to 12
    typedef enum logic [3:0] {
        opAdd    = 4'h0,
        opSub    = 4'h1,
        opXor    = 4'h2,
        opRed    = 4'h3,
        opSll    = 4'h4,
        opSra    = 4'h5,
        opRor    = 4'h6,
        opPaddsb = 4'h7,
        opLw     = 4'h8,
        opSw     = 4'h9,
        opLlb    = 4'hA,
        opLhb    = 4'hB,
        opB      = 4'hC,
        opBr     = 4'hD,
        opPcs    = 4'hE,
        opHlt    = 4'hF
    } opcodeT;

    // Sequencer states, one instruction in flight
    typedef enum logic [2:0] {
        stFetch     = 3'd0, // Instruction read on the bus
        stDecode    = 3'd1, // Register read and ALU
        stMemory    = 3'd2, // LW and SW only
        stWriteback = 3'd3, // Register, flag and PC update
        stHalted    = 3'd4  // Parked until reset
    } seqStateT;

    // Branch conditions in instruction bits 11 to 9
    typedef enum logic [2:0] {
        neq    = 3'd0, // Z clear
        eq     = 3'd1, // Z set
        gt     = 3'd2, // Z and N clear
        lt     = 3'd3, // N set
        gte    = 3'd4, // Z set or N clear
        lte    = 3'd5, // Z set or N set
        ovf    = 3'd6, // V set
        uncond = 3'd7  // Always taken
    } condT;

endpackage

/* design/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         memReq,
    output logic                         memWe,
    output logic [cpuPkg::DataWidth-1:0] memAddr,
    output logic [cpuPkg::DataWidth-1:0] memWdata,
    input  logic                         memAck,
    input  logic [cpuPkg::DataWidth-1:0] memRdata,
    output logic                         halted
);

    cpuPkg::opcodeT opcode;
    logic aluSrc, memToReg, regWrite, regSrc, memEnable, memWrite;
    logic branch, branchReg, halt, pcSave, zEn, nvEn;
    logic [cpuPkg::DataWidth-1:0] aluA, aluB, aluImm, aluResult;
    logic aluZero, aluNegative, aluOverflow;
    logic [cpuPkg::RegAddrWidth-1:0] readAddr1, readAddr2, writeAddr;
    logic writeEn;
    logic [cpuPkg::DataWidth-1:0] writeData, readData1, readData2;
    logic accStart, accWe, accDone;
    logic [cpuPkg::DataWidth-1:0] accAddr, accWdata, accRdata;

    //////////////////////////////
    // Decode and execute
    //////////////////////////////
    controlUnit i_controlUnit (
        .opcode(opcode), .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
        .regSrc(regSrc), .memEnable(memEnable), .memWrite(memWrite), .branch(branch),
        .branchReg(branchReg), .halt(halt), .pcSave(pcSave), .zEn(zEn), .nvEn(nvEn)
    );

    alu i_alu (
        .op(opcode), .a(aluA), .b(aluB), .imm(aluImm), .result(aluResult),
        .zero(aluZero), .negative(aluNegative), .overflow(aluOverflow)
    );

    registerFile i_registerFile (
        .clk(clk), .reset(reset), .readAddr1(readAddr1), .readAddr2(readAddr2),
        .writeAddr(writeAddr), .writeEn(writeEn), .writeData(writeData),
        .readData1(readData1), .readData2(readData2)
    );

    // Shared instruction and data port
    memBusMaster i_memBusMaster (
        .clk(clk), .reset(reset), .accStart(accStart), .accWe(accWe), .accAddr(accAddr),
        .accWdata(accWdata), .accDone(accDone), .accRdata(accRdata), .memReq(memReq),
        .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memAck(memAck),
        .memRdata(memRdata)
    );

    instrSequencer i_instrSequencer (
        .clk(clk), .reset(reset), .aluSrc(aluSrc), .memToReg(memToReg),
        .regWrite(regWrite), .regSrc(regSrc), .memEnable(memEnable), .memWrite(memWrite),
        .branch(branch), .branchReg(branchReg), .halt(halt), .pcSave(pcSave),
        .zEn(zEn), .nvEn(nvEn), .opcode(opcode), .aluResult(aluResult),
        .aluZero(aluZero), .aluNegative(aluNegative), .aluOverflow(aluOverflow),
        .readData1(readData1), .readData2(readData2), .readAddr1(readAddr1),
        .readAddr2(readAddr2), .writeAddr(writeAddr), .writeEn(writeEn),
        .writeData(writeData), .aluA(aluA), .aluB(aluB), .aluImm(aluImm),
        .accStart(accStart), .accWe(accWe), .accAddr(accAddr), .accWdata(accWdata),
        .accDone(accDone), .accRdata(accRdata), .halted(halted)
    );

endmodule

/* design/instrSequencer.sv */
`timescale 1ns/1ps

module instrSequencer (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            aluSrc,
    input  logic                            memToReg,
    input  logic                            regWrite,
    input  logic                            regSrc,
    input  logic                            memEnable,
    input  logic                            memWrite,
    input  logic                            branch,
    input  logic                            branchReg,
    input  logic                            halt,
    input  logic                            pcSave,
    input  logic                            zEn,
    input  logic                            nvEn,
    output cpuPkg::opcodeT                  opcode,
    input  logic [cpuPkg::DataWidth-1:0]    aluResult,
    input  logic                            aluZero,
    input  logic                            aluNegative,
    input  logic                            aluOverflow,
    input  logic [cpuPkg::DataWidth-1:0]    readData1,
    input  logic [cpuPkg::DataWidth-1:0]    readData2,
    output logic [cpuPkg::RegAddrWidth-1:0] readAddr1,
    output logic [cpuPkg::RegAddrWidth-1:0] readAddr2,
    output logic [cpuPkg::RegAddrWidth-1:0] writeAddr,
    output logic                            writeEn,
    output logic [cpuPkg::DataWidth-1:0]    writeData,
    output logic [cpuPkg::DataWidth-1:0]    aluA,
    output logic [cpuPkg::DataWidth-1:0]    aluB,
    output logic [cpuPkg::DataWidth-1:0]    aluImm,
    output logic                            accStart,
    output logic                            accWe,
    output logic [cpuPkg::DataWidth-1:0]    accAddr,
    output logic [cpuPkg::DataWidth-1:0]    accWdata,
    input  logic                            accDone,
    input  logic [cpuPkg::DataWidth-1:0]    accRdata,
    output logic                            halted
);

    cpuPkg::seqStateT state;
    logic [cpuPkg::DataWidth-1:0] pc;
    logic [cpuPkg::DataWidth-1:0] instr;
    logic [cpuPkg::DataWidth-1:0] aluOut;    // ALU result held from decode
    logic [cpuPkg::DataWidth-1:0] storeData; // SW data held from decode
    logic [cpuPkg::DataWidth-1:0] pcPlus2;
    logic [cpuPkg::DataWidth-1:0] branchTarget;
    logic flagZ, flagN, flagV;
    logic resZ, resN, resV; // ALU flags held from decode
    logic accBusy;          // Bus access outstanding
    logic taken;

    //////////////////////////////
    // Datapath selects
    //////////////////////////////
    assign opcode    = cpuPkg::opcodeT'(instr[15:12]);
    assign readAddr1 = regSrc ? instr[11:8] : instr[7:4];   // rd for LLB and LHB
    assign readAddr2 = memWrite ? instr[11:8] : instr[3:0]; // SW data register sits in rd
    assign writeAddr = instr[11:8];
    assign aluA      = readData1;
    assign aluImm    = {8'h00, instr[7:0]};
    assign aluB      = aluSrc ? aluImm : readData2;
    assign writeEn   = regWrite && (state == cpuPkg::stWriteback);
    assign writeData = pcSave ? pcPlus2 : (memToReg ? accRdata : aluOut);
    assign pcPlus2   = pc + 16'd2;

    // B is PC relative in words, BR jumps to rs
    assign branchTarget = branchReg ? readData1 : pcPlus2 + {{6{instr[8]}}, instr[8:0], 1'b0};

    // Bus requests, one per fetch and one per data access
    assign accStart = ((state == cpuPkg::stFetch) || (state == cpuPkg::stMemory)) && !accBusy;
    assign accWe    = (state == cpuPkg::stMemory) && memWrite;
    assign accAddr  = (state == cpuPkg::stMemory) ? aluOut : pc;
    assign accWdata = storeData;
    assign halted   = (state == cpuPkg::stHalted);

    always_comb begin
        case (cpuPkg::condT'(instr[11:9]))
            cpuPkg::neq:  taken = !flagZ;
            cpuPkg::eq:   taken = flagZ;
            cpuPkg::gt:   taken = !flagZ && !flagN;
            cpuPkg::lt:   taken = flagN;
            cpuPkg::gte:  taken = flagZ || !flagN;
            cpuPkg::lte:  taken = flagZ || flagN;
            cpuPkg::ovf:  taken = flagV;
            default:      taken = 1'b1; // always
        endcase
    end

    //////////////////////////////
    // Sequencer FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= cpuPkg::stFetch;
            pc      <= '0;
            flagZ   <= 1'b0;
            flagN   <= 1'b0;
            flagV   <= 1'b0;
            accBusy <= 1'b0;
        end else begin
            if (accStart) accBusy <= 1'b1;
            else if (accDone) accBusy <= 1'b0;
            case (state)
                cpuPkg::stFetch: if (accDone) state <= cpuPkg::stDecode;
                cpuPkg::stDecode: begin
                    if (halt) state <= cpuPkg::stHalted;
                    else if (memEnable) state <= cpuPkg::stMemory;
                    else state <= cpuPkg::stWriteback;
                end
                cpuPkg::stMemory: if (accDone) state <= cpuPkg::stWriteback;
                cpuPkg::stWriteback: begin
                    pc    <= (branch && taken) ? branchTarget : pcPlus2;
                    state <= cpuPkg::stFetch;
                    if (zEn) flagZ <= resZ;
                    if (nvEn) begin
                        flagN <= resN;
                        flagV <= resV;
                    end
                end
                default: state <= cpuPkg::stHalted; // Stays until reset
            endcase
        end
    end

    // Instruction and decode results
    always_ff @(posedge clk) begin
        if ((state == cpuPkg::stFetch) && accDone) instr <= accRdata;
        if (state == cpuPkg::stDecode) begin
            aluOut    <= aluResult;
            storeData <= readData2;
            resZ      <= aluZero;
            resN      <= aluNegative;
            resV      <= aluOverflow;
        end
    end

endmodule

/* design/memBusMaster.sv */
`timescale 1ns/1ps

module memBusMaster (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         accStart, // One-cycle access request
    input  logic                         accWe,
    input  logic [cpuPkg::DataWidth-1:0] accAddr,
    input  logic [cpuPkg::DataWidth-1:0] accWdata,
    output logic                         accDone,  // One-cycle completion pulse
    output logic [cpuPkg::DataWidth-1:0] accRdata, // Held until next access
    output logic                         memReq,
    output logic                         memWe,
    output logic [cpuPkg::DataWidth-1:0] memAddr,
    output logic [cpuPkg::DataWidth-1:0] memWdata,
    input  logic                         memAck,
    input  logic [cpuPkg::DataWidth-1:0] memRdata
);

    typedef enum logic [1:0] {
        busIdle,     // Ack is low, ready for a request
        busWaitAck,  // memReq high
        busWaitDrop  // memReq low, ack still high
    } busStateT;

    busStateT busState;
    logic     pending; // Request taken while ack was still high

    always_ff @(posedge clk) begin
        if (reset) begin
            busState <= busIdle;
            memReq   <= 1'b0;
            accDone  <= 1'b0;
            pending  <= 1'b0;
        end else begin
            accDone <= 1'b0;
            case (busState)
                busIdle: if (accStart) begin
                    memReq   <= 1'b1;
                    busState <= busWaitAck;
                end
                busWaitAck: if (memAck) begin
                    memReq   <= 1'b0; // Phase 3
                    accDone  <= 1'b1;
                    busState <= busWaitDrop;
                end
                busWaitDrop: begin
                    if (accStart) pending <= 1'b1;
                    if (!memAck) begin // Phase 4 seen
                        memReq   <= pending || accStart;
                        busState <= (pending || accStart) ? busWaitAck : busIdle;
                        pending  <= 1'b0;
                    end
                end
                default: busState <= busIdle;
            endcase
        end
    end

    // Address and data captured with the request, stable while memReq is high
    always_ff @(posedge clk) begin
        if (accStart) begin
            memWe    <= accWe;
            memAddr  <= {accAddr[15:1], 1'b0}; // Word aligned
            memWdata <= accWdata;
        end
        if ((busState == busWaitAck) && memAck) accRdata <= memRdata;
    end

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [cpuPkg::RegAddrWidth-1:0] readAddr1,
    input  logic [cpuPkg::RegAddrWidth-1:0] readAddr2,
    input  logic [cpuPkg::RegAddrWidth-1:0] writeAddr,
    input  logic                            writeEn,
    input  logic [cpuPkg::DataWidth-1:0]    writeData,
    output logic [cpuPkg::DataWidth-1:0]    readData1,
    output logic [cpuPkg::DataWidth-1:0]    readData2
);

    logic [cpuPkg::DataWidth-1:0] regs [0:(1 << cpuPkg::RegAddrWidth)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < (1 << cpuPkg::RegAddrWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin // Writes to r0 are dropped
            regs[writeAddr] <= writeData;
        end
    end

    // Write-through bypass, r0 hard zero
    assign readData1 = (readAddr1 == '0) ? '0 :
                       (writeEn && (writeAddr == readAddr1)) ? writeData : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 :
                       (writeEn && (writeAddr == readAddr2)) ? writeData : regs[readAddr2];

endmodule

/* filelist.f */
design/cpuPkg.sv
design/controlUnit.sv
design/alu.sv
design/registerFile.sv
design/memBusMaster.sv
design/instrSequencer.sv
design/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTb.sv

/* sim/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam int          NumCases      = 31;
    localparam int          TimeoutCycles = 2000; // Per program, in clock cycles
    localparam logic [15:0] StoreAddr     = 16'h0080;

    typedef struct packed {
        cpuPkg::opcodeT op;      // Operation under test
        cpuPkg::opcodeT pre;     // Sets the flags first
        cpuPkg::opcodeT mid;     // Runs between, LLB leaves flags alone
        logic [15:0]    a;
        logic [15:0]    b;
        logic [7:0]     imm;     // Immediate, or condition code for branches
        logic [15:0]    expWord; // Word stored at StoreAddr
    } testCaseT;

    // Branch rows store 0022 when taken, 0011 when not
    testCaseT cases [NumCases] = '{
        '{cpuPkg::opAdd, cpuPkg::opAdd, cpuPkg::opLlb, 16'h7000, 16'h2000, 8'h00, 16'h7FFF},
        '{cpuPkg::opAdd, cpuPkg::opAdd, cpuPkg::opLlb, 16'h8000, 16'hF000, 8'h00, 16'h8000},
        '{cpuPkg::opSub, cpuPkg::opAdd, cpuPkg::opLlb, 16'h8000, 16'h0001, 8'h00, 16'h8000},
        '{cpuPkg::opSub, cpuPkg::opAdd, cpuPkg::opLlb, 16'h7FFF, 16'hFFFF, 8'h00, 16'h7FFF},
        '{cpuPkg::opSub, cpuPkg::opAdd, cpuPkg::opLlb, 16'h1234, 16'h0234, 8'h00, 16'h1000},
        '{cpuPkg::opXor, cpuPkg::opAdd, cpuPkg::opLlb, 16'hF0F0, 16'h3C3C, 8'h00, 16'hCCCC},
        '{cpuPkg::opSll, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0F0F, 16'h0000, 8'h04, 16'hF0F0},
        '{cpuPkg::opSll, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0001, 16'h0000, 8'h0F, 16'h8000},
        '{cpuPkg::opSra, cpuPkg::opAdd, cpuPkg::opLlb, 16'h8010, 16'h0000, 8'h04, 16'hF801},
        '{cpuPkg::opRor, cpuPkg::opAdd, cpuPkg::opLlb, 16'h1234, 16'h0000, 8'h04, 16'h4123},
        '{cpuPkg::opRor, cpuPkg::opAdd, cpuPkg::opLlb, 16'h1234, 16'h0000, 8'h08, 16'h3412},
        '{cpuPkg::opLlb, cpuPkg::opAdd, cpuPkg::opLlb, 16'hABCD, 16'h0000, 8'h12, 16'hAB12},
        '{cpuPkg::opLhb, cpuPkg::opAdd, cpuPkg::opLlb, 16'hABCD, 16'h0000, 8'h34, 16'h34CD},
        '{cpuPkg::opPaddsb, cpuPkg::opAdd, cpuPkg::opLlb, 16'h7181, 16'h1F8F, 8'h00, 16'h7080},
        '{cpuPkg::opRed, cpuPkg::opAdd, cpuPkg::opLlb, 16'h7F7F, 16'h7F7F, 8'h00, 16'h01FC},
        '{cpuPkg::opRed, cpuPkg::opAdd, cpuPkg::opLlb, 16'h8080, 16'h8080, 8'h00, 16'hFE00},
        '{cpuPkg::opLw, cpuPkg::opAdd, cpuPkg::opLlb, 16'hBEEF, 16'h0000, 8'h00, 16'hBEEF},
        '{cpuPkg::opPcs, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0000, 16'h0000, 8'h00, 16'h0012},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0005, 16'hFFFB, 8'h01, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0005, 16'hFFFB, 8'h00, 16'h0011},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0001, 16'h0001, 8'h02, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opSub, cpuPkg::opLlb, 16'h0001, 16'h0002, 8'h03, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opSub, cpuPkg::opLlb, 16'h0001, 16'h0002, 8'h04, 16'h0011},
        '{cpuPkg::opB, cpuPkg::opSub, cpuPkg::opLlb, 16'h0001, 16'h0002, 8'h05, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opLlb, 16'h7000, 16'h2000, 8'h06, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0001, 16'h0001, 8'h06, 16'h0011},
        '{cpuPkg::opBr, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0001, 16'h0001, 8'h07, 16'h0022},
        '{cpuPkg::opBr, cpuPkg::opAdd, cpuPkg::opLlb, 16'h0005, 16'hFFFB, 8'h00, 16'h0011},
        '{cpuPkg::opBr, cpuPkg::opAdd, cpuPkg::opPaddsb, 16'h0005, 16'hFFFB, 8'h01, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opSub, cpuPkg::opXor, 16'h0001, 16'h0002, 8'h03, 16'h0022},
        '{cpuPkg::opB, cpuPkg::opAdd, cpuPkg::opXor, 16'h7000, 16'h2000, 8'h06, 16'h0022}
    };

    logic        clk;
    logic        reset;
    logic        memReq;
    logic        memWe;
    logic [15:0] memAddr;
    logic [15:0] memWdata;
    logic        memAck;
    logic [15:0] memRdata;
    logic        halted;

    logic [15:0] mem [0:255]; // Word array, byte address bits 8 to 1
    integer      seed = 32'h05dd_7255;
    int          ackWait;     // Cycles left before ack, -1 when idle
    int          writeCount;  // Every write seen by the memory
    logic        storeSeen;
    logic [15:0] storedWord;
    logic        firstSeen;
    logic [15:0] firstAddr;   // First request after reset
    int          mismatches;
    int          failures;

    cpuTop i_cpuTop (
        .clk(clk), .reset(reset), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWdata(memWdata), .memAck(memAck), .memRdata(memRdata), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////
    always @(posedge clk) begin
        if (reset) begin
            memAck    <= 1'b0;
            ackWait   = -1;
            storeSeen <= 1'b0;
            firstSeen <= 1'b0;
        end else if (memReq && !memAck) begin
            if (!firstSeen) begin
                firstSeen <= 1'b1;
                firstAddr <= memAddr;
            end
            if (ackWait < 0) ackWait = $unsigned($random(seed)) % 6; // 0 to 5 cycles
            if (ackWait == 0) begin
                memAck   <= 1'b1;
                memRdata <= mem[memAddr[8:1]];
                if (memWe) begin
                    mem[memAddr[8:1]] = memWdata;
                    writeCount++;
                    if (memAddr == StoreAddr) begin
                        storeSeen  <= 1'b1;
                        storedWord <= memWdata;
                    end
                end
                ackWait = -1;
            end else begin
                ackWait = ackWait - 1;
            end
        end else if (!memReq && memAck) begin
            memAck <= 1'b0; // Phase 4
        end
    end

    // Opcode, rd and a low byte
    function automatic logic [15:0] instr(input cpuPkg::opcodeT op, input logic [3:0] rd,
                                          input logic [7:0] low);
        instr = {op, rd, low};
    endfunction

    task automatic loadProgram(input testCaseT tc);
        for (int i = 0; i < 256; i++) begin
            mem[i] = 16'hF000 | i; // Stray fetches land on HLT
        end
        mem[0] = instr(cpuPkg::opLlb, 4'd1, tc.a[7:0]);
        mem[1] = instr(cpuPkg::opLhb, 4'd1, tc.a[15:8]);
        mem[2] = instr(cpuPkg::opLlb, 4'd2, tc.b[7:0]);
        mem[3] = instr(cpuPkg::opLhb, 4'd2, tc.b[15:8]);
        mem[4] = instr(cpuPkg::opLlb, 4'd4, StoreAddr[7:0]); // Store base
        mem[5] = instr(cpuPkg::opLlb, 4'd7, 8'h16);          // BR target, word 11
        mem[6] = instr(tc.pre, 4'd3, 8'h12);                 // r3 = r1 op r2
        mem[7] = instr(tc.mid, 4'd5, 8'h12);
        mem[10] = instr(cpuPkg::opHlt, 4'd0, 8'h00);
        case (tc.op)
            cpuPkg::opB, cpuPkg::opBr: begin
                if (tc.op == cpuPkg::opB) mem[8] = {cpuPkg::opB, tc.imm[2:0], 9'd2};
                else mem[8] = {cpuPkg::opBr, tc.imm[2:0], 1'b0, 4'd7, 4'd0};
                mem[9]  = instr(cpuPkg::opLlb, 4'd6, 8'h11); // Fall-through marker
                mem[10] = {cpuPkg::opB, 3'd7, 9'd1};          // Skip the taken marker
                mem[11] = instr(cpuPkg::opLlb, 4'd6, 8'h22);
                mem[12] = instr(cpuPkg::opSw, 4'd6, 8'h40);
                mem[13] = instr(cpuPkg::opHlt, 4'd0, 8'h00);
            end
            cpuPkg::opPcs: begin
                mem[8] = instr(cpuPkg::opPcs, 4'd6, 8'h00);
                mem[9] = instr(cpuPkg::opSw, 4'd6, 8'h40);
            end
            cpuPkg::opLw: begin
                mem[8]  = instr(cpuPkg::opSw, 4'd1, 8'h41); // Word after StoreAddr
                mem[9]  = instr(cpuPkg::opLw, 4'd6, 8'h41);
                mem[10] = instr(cpuPkg::opSw, 4'd6, 8'h40);
                mem[11] = instr(cpuPkg::opHlt, 4'd0, 8'h00);
            end
            cpuPkg::opLlb, cpuPkg::opLhb: begin
                mem[8] = instr(tc.op, 4'd1, tc.imm);
                mem[9] = instr(cpuPkg::opSw, 4'd1, 8'h40);
            end
            cpuPkg::opSll, cpuPkg::opSra, cpuPkg::opRor: begin
                mem[8] = instr(tc.op, 4'd3, {4'd1, tc.imm[3:0]});
                mem[9] = instr(cpuPkg::opSw, 4'd3, 8'h40);
            end
            default: begin
                mem[8] = instr(tc.op, 4'd3, 8'h12);
                mem[9] = instr(cpuPkg::opSw, 4'd3, 8'h40);
            end
        endcase
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        testCaseT tc;
        int       waitCount;
        reset      = 1'b1;
        memAck     = 1'b0;
        memRdata   = '0;
        writeCount = 0;
        mismatches = 0;
        failures   = 0;
        for (int i = 0; i < NumCases; i++) begin
            tc = cases[i];
            @(posedge clk);
            reset <= 1'b1;
            loadProgram(tc);
            repeat (10) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            assert (!halted) else begin
                failures++;
                $display("Case %0d: halted still high after reset", i);
            end
            waitCount = 0;
            while (!halted && waitCount < TimeoutCycles) begin
                @(negedge clk);
                waitCount++;
            end
            assert (halted) else begin
                failures++;
                $display("Case %0d: timed out waiting for halted", i);
            end
            repeat (5) @(negedge clk); // Bus must stay quiet here
            assert (firstSeen && (firstAddr == 16'h0000)) else begin
                failures++;
                $display("Case %0d: first fetch after reset was not at address 0", i);
            end
            assert (storeSeen) else begin
                failures++;
                $display("Case %0d: no store to the result address", i);
            end
            if (storeSeen) begin
                assert (storedWord == tc.expWord) else begin
                    mismatches++;
                    $display("MISMATCH at %0t: storedWord expected %h actual %h (case %0d)",
                             $time, tc.expWord, storedWord, i);
                end
            end
        end
        $display("Done: %0d mismatches, %0d other errors, %0d bus assertion errors, %0d writes",
                 mismatches, failures, i_cpuTop.i_cpuTopChk.errorCount, writeCount);
        if ((mismatches == 0) && (failures == 0) && (i_cpuTop.i_cpuTopChk.errorCount == 0)) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* sim/cpuTop_chk.sv */
`timescale 1ns/1ps

module cpuTopChk (
    input logic        clk,
    input logic        reset,
    input logic        memReq,
    input logic        memAck,
    input logic        memWe,
    input logic [15:0] memAddr,
    input logic        halted
);

    int errorCount = 0; // Assertion failures so far

    // No new request while the previous ack is still up
    reqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
        (!memReq && memAck) |=> !memReq)
        else begin
            $error("memReq raised while memAck still high");
            errorCount++;
        end

    // Address and direction frozen for the whole request
    addrStable: assert property (@(posedge clk) disable iff (reset)
        (memReq && $past(memReq)) |-> ($stable(memAddr) && $stable(memWe)))
        else begin
            $error("memAddr or memWe changed during a request");
            errorCount++;
        end

    // Halt is sticky, bus quiet
    haltSticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> (halted && !memReq))
        else begin
            $error("halted dropped or bus request after halt");
            errorCount++;
        end

endmodule

bind cpuTop cpuTopChk i_cpuTopChk (
    .clk(clk), .reset(reset), .memReq(memReq), .memAck(memAck),
    .memWe(memWe), .memAddr(memAddr), .halted(halted)
);
